//--- hdl/cad_params.svh
`ifndef CAD_PARAMS_SVH
`define CAD_PARAMS_SVH

`default_nettype none

// Image and kernel geometry
`define IMG_SIZE      8
`define KSIZE         5
`define OUT_SIZE      (`IMG_SIZE - `KSIZE + 1)
`define IMG_PIXELS    (`IMG_SIZE * `IMG_SIZE)
`define KER_TAPS      (`KSIZE * `KSIZE)

// Per-load counts, raised for full-size runs
`define IMG_COUNT     2
`define KERNEL_COUNT  2
`define QUERY_COUNT   3

// Storage depths and result width
`define IMG_DEPTH     (`IMG_COUNT * `IMG_PIXELS)
`define KER_DEPTH     (`KERNEL_COUNT * `KER_TAPS)
`define RESULT_W      20

`default_nettype wire

`endif

//--- hdl/cad_pkg.sv
`include "cad_params.svh"
`default_nettype none

package cad_pkg;

  // Stored bytes, both signed two's complement
  typedef logic signed [7:0] pixel_t;
  typedef logic signed [7:0] weight_t;

  // Memory addresses sized from the store depths
  typedef logic [$clog2(`IMG_DEPTH)-1:0] img_addr_t;
  typedef logic [$clog2(`KER_DEPTH)-1:0] ker_addr_t;

  // Image or kernel number carried on matrix_idx
  typedef logic [3:0] idx_t;

  // Full 25-tap sum
  typedef logic signed [`RESULT_W-1:0] result_t;

  // Main controller FSM
  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_wait_idx,
    st_process
  } cad_state_t;

endpackage

`default_nettype wire

//--- hdl/sram_bank.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module sram_bank
  import cad_pkg::*;
#(
  parameter type word_t = pixel_t,
  parameter int  depth  = `IMG_DEPTH
)
(
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] waddr,
  input  word_t                    wdata,
  input  logic [$clog2(depth)-1:0] raddr,
  output word_t                    rdata
);

  word_t mem [depth];

  // Registered read, one cycle after the address
  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- hdl/cad_ctrl.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module cad_ctrl
  import cad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  logic      in_valid2,
  input  pixel_t    matrix,
  input  idx_t      matrix_idx,
  input  logic      done,
  output logic      img_we,
  output img_addr_t img_waddr,
  output logic      ker_we,
  output ker_addr_t ker_waddr,
  output pixel_t    wdata,
  output logic      start,
  output idx_t      img_idx,
  output idx_t      ker_idx
);

  localparam int LOAD_TOTAL = `IMG_DEPTH + `KER_DEPTH;
  localparam int LOAD_W     = $clog2(LOAD_TOTAL + 1);
  localparam int QCNT_W     = $clog2(`QUERY_COUNT + 1);

  cad_state_t        state;
  cad_state_t        next_state;
  logic [LOAD_W-1:0] load_cnt;
  logic [QCNT_W-1:0] query_cnt;
  logic              idx_phase;
  logic              loading;
  logic              load_last;
  logic              query_last;
  logic              in_image;

  // ------------------------------------------------------------
  // Load stream split
  // ------------------------------------------------------------
  // First byte may land while still idle
  assign loading    = in_valid && (state == st_idle || state == st_load);
  assign load_last  = loading && (load_cnt == LOAD_W'(LOAD_TOTAL - 1));
  assign query_last = (query_cnt == QCNT_W'(`QUERY_COUNT - 1));
  assign in_image   = (load_cnt < LOAD_W'(`IMG_DEPTH));

  assign img_we    = loading && in_image;
  assign ker_we    = loading && !in_image;
  assign img_waddr = img_addr_t'(load_cnt);
  assign ker_waddr = ker_addr_t'(load_cnt - LOAD_W'(`IMG_DEPTH));
  assign wdata     = matrix;

  // ------------------------------------------------------------
  // Main FSM
  // ------------------------------------------------------------
  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:
        if (in_valid)
          next_state = st_load;
      st_load:
        if (load_last)
          next_state = st_wait_idx;
      st_wait_idx:
        // Second index cycle starts the query
        if (in_valid2 && idx_phase)
          next_state = st_process;
      st_process:
        if (done)
          next_state = query_last ? st_idle : st_wait_idx;
      default:
        next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      load_cnt  <= '0;
      query_cnt <= '0;
      idx_phase <= 1'b0;
      start     <= 1'b0;
    end
    else
    begin
      state <= next_state;
      start <= (state == st_wait_idx) && in_valid2 && idx_phase;

      // Counter is free again once the load has finished
      if (state == st_wait_idx)
        load_cnt <= '0;
      else if (loading)
        load_cnt <= load_cnt + 1'b1;

      if (state == st_wait_idx && in_valid2)
        idx_phase <= !idx_phase;

      if (state == st_process && done)
        query_cnt <= query_last ? '0 : query_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Index latches, held until the engine is done
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (state == st_wait_idx && in_valid2)
    begin
      if (!idx_phase)
        img_idx <= matrix_idx;
      else
        ker_idx <= matrix_idx;
    end
  end

endmodule

`default_nettype wire

//--- hdl/conv_engine.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module conv_engine
  import cad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  idx_t      img_idx,
  input  idx_t      ker_idx,
  input  pixel_t    img_rdata,
  input  weight_t   ker_rdata,
  output img_addr_t img_raddr,
  output ker_addr_t ker_raddr,
  output logic      result_valid,
  output result_t   result,
  output logic      done
);

  localparam int OW = $clog2(`OUT_SIZE);
  localparam int KW = $clog2(`KSIZE);

  logic          busy;
  logic          drain;
  logic [OW-1:0] ox;
  logic [OW-1:0] oy;
  logic [KW-1:0] kr;
  logic [KW-1:0] kc;
  logic          tap_en;
  logic          first_tap;
  logic          last_tap;
  logic          last_pos;
  logic          tap_d;
  logic          first_d;
  logic          last_d;
  logic          fin_d1;
  logic          fin_d2;
  logic signed [15:0] prod;
  result_t       acc;
  result_t       acc_base;
  result_t       sum_next;

  assign tap_en    = busy && !drain;
  assign first_tap = (kr == '0) && (kc == '0);
  assign last_tap  = (kr == KW'(`KSIZE - 1)) && (kc == KW'(`KSIZE - 1));
  assign last_pos  = (ox == OW'(`OUT_SIZE - 1)) && (oy == OW'(`OUT_SIZE - 1));

  // ------------------------------------------------------------
  // Window walker
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      drain <= 1'b0;
      ox    <= '0;
      oy    <= '0;
      kr    <= '0;
      kc    <= '0;
    end
    else if (start)
    begin
      busy  <= 1'b1;
      drain <= 1'b0;
      ox    <= '0;
      oy    <= '0;
      kr    <= '0;
      kc    <= '0;
    end
    else if (busy)
    begin
      if (drain)
      begin
        // Last tap is in the MAC, step to next output position
        drain <= 1'b0;
        if (ox == OW'(`OUT_SIZE - 1))
        begin
          ox <= '0;
          if (oy == OW'(`OUT_SIZE - 1))
            busy <= 1'b0;
          else
            oy <= oy + 1'b1;
        end
        else
          ox <= ox + 1'b1;
      end
      else if (last_tap)
      begin
        drain <= 1'b1;
        kr    <= '0;
        kc    <= '0;
      end
      else if (kc == KW'(`KSIZE - 1))
      begin
        kc <= '0;
        kr <= kr + 1'b1;
      end
      else
        kc <= kc + 1'b1;
    end
  end

  // Row-major addressing inside each stored image and kernel
  always_comb
  begin
    img_raddr = img_addr_t'(int'(img_idx) * `IMG_PIXELS
                + (int'(oy) + int'(kr)) * `IMG_SIZE + int'(ox) + int'(kc));
    ker_raddr = ker_addr_t'(int'(ker_idx) * `KER_TAPS + int'(kr) * `KSIZE + int'(kc));
  end

  // ------------------------------------------------------------
  // MAC, one cycle behind the addresses
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tap_d        <= 1'b0;
      first_d      <= 1'b0;
      last_d       <= 1'b0;
      fin_d1       <= 1'b0;
      fin_d2       <= 1'b0;
      result_valid <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      tap_d        <= tap_en;
      first_d      <= tap_en && first_tap;
      last_d       <= tap_en && last_tap;
      fin_d1       <= tap_en && last_tap && last_pos;
      fin_d2       <= fin_d1;
      result_valid <= last_d;
      // One cycle after the final result
      done         <= fin_d2;
    end
  end

  assign prod = img_rdata * ker_rdata;

  always_comb
  begin
    acc_base = first_d ? result_t'(0) : acc;
    sum_next = acc_base + result_t'(prod);
  end

  always_ff @(posedge clk)
  begin
    if (tap_d)
      acc <= sum_next;
    if (last_d)
      result <= sum_next;
  end

endmodule

`default_nettype wire

//--- hdl/result_serializer.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module result_serializer
  import cad_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    result_valid,
  input  result_t result,
  output logic    out_valid,
  output logic    out_value
);

  localparam int CNT_W = $clog2(`RESULT_W);

  result_t          shreg;
  logic [CNT_W-1:0] bit_cnt;

  // LSB first, one bit per cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg     <= '0;
      bit_cnt   <= '0;
      out_valid <= 1'b0;
    end
    else if (result_valid)
    begin
      shreg     <= result;
      bit_cnt   <= '0;
      out_valid <= 1'b1;
    end
    else if (out_valid)
    begin
      shreg <= shreg >> 1;
      if (bit_cnt == CNT_W'(`RESULT_W - 1))
        out_valid <= 1'b0;
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign out_value = out_valid & shreg[0];

endmodule

`default_nettype wire

//--- hdl/cad_top.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module cad_top
  import cad_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic in_valid2,
  input  logic [7:0] matrix,
  input  logic [3:0] matrix_idx,
  output logic out_valid,
  output logic out_value
);

  // Load path
  logic      img_we;
  logic      ker_we;
  img_addr_t img_waddr;
  ker_addr_t ker_waddr;
  pixel_t    wdata;

  // Query path
  logic      start;
  logic      done;
  idx_t      img_idx;
  idx_t      ker_idx;

  // Read path and result
  img_addr_t img_raddr;
  ker_addr_t ker_raddr;
  pixel_t    img_rdata;
  weight_t   ker_rdata;
  logic      result_valid;
  result_t   result;

  cad_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix     (matrix),
    .matrix_idx (matrix_idx),
    .done       (done),
    .img_we     (img_we),
    .img_waddr  (img_waddr),
    .ker_we     (ker_we),
    .ker_waddr  (ker_waddr),
    .wdata      (wdata),
    .start      (start),
    .img_idx    (img_idx),
    .ker_idx    (ker_idx)
  );

  sram_bank #(.word_t(pixel_t), .depth(`IMG_DEPTH)) u_img_mem (
    .clk   (clk),
    .we    (img_we),
    .waddr (img_waddr),
    .wdata (wdata),
    .raddr (img_raddr),
    .rdata (img_rdata)
  );

  sram_bank #(.word_t(weight_t), .depth(`KER_DEPTH)) u_ker_mem (
    .clk   (clk),
    .we    (ker_we),
    .waddr (ker_waddr),
    .wdata (wdata),
    .raddr (ker_raddr),
    .rdata (ker_rdata)
  );

  conv_engine u_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .img_idx      (img_idx),
    .ker_idx      (ker_idx),
    .img_rdata    (img_rdata),
    .ker_rdata    (ker_rdata),
    .img_raddr    (img_raddr),
    .ker_raddr    (ker_raddr),
    .result_valid (result_valid),
    .result       (result),
    .done         (done)
  );

  result_serializer u_ser (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .result       (result),
    .out_valid    (out_valid),
    .out_value    (out_value)
  );

endmodule

`default_nettype wire

//--- sim/cad_properties.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module cad_properties
(
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_valid2,
  input logic out_valid
);

  int run_len;

  // Length of the current out_valid run
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      run_len <= 0;
    else if (out_valid)
      run_len <= run_len + 1;
    else
      run_len <= 0;
  end

  // ------------------------------------------------------------
  // Top-level protocol
  // ------------------------------------------------------------
  a_quiet_on_input: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid || in_valid2) |-> !out_valid)
    else $error("out_valid high while in_valid or in_valid2 is high");

  a_one_input_kind: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_valid && in_valid2))
    else $error("in_valid and in_valid2 high in the same cycle");

  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |=> !out_valid)
    else $error("out_valid high right after reset release");

  a_run_not_long: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> run_len < `RESULT_W)
    else $error("out_valid run longer than one result");

  a_run_full: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |-> run_len == `RESULT_W)
    else $error("out_valid run ended after %0d cycles", run_len);

endmodule

bind cad_top cad_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_valid2 (in_valid2),
  .out_valid (out_valid)
);

`default_nettype wire

//--- sim/cad_checker.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module cad_checker
  import cad_pkg::*;
#(
  parameter int num_queries = `QUERY_COUNT + 1
)
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic in_valid2,
  input  logic out_valid,
  input  logic out_value,
  input  logic arm,
  input  int   query_sel,
  output int   result_cnt,
  output int   mismatch_errs,
  output int   other_errs
);

  localparam int RESULTS    = `OUT_SIZE * `OUT_SIZE;
  localparam int EXP_BASE   = `IMG_DEPTH + `KER_DEPTH + 2 * num_queries;
  localparam int CASE_WORDS = EXP_BASE + num_queries * RESULTS;

  logic [19:0] exp_mem [CASE_WORDS];
  result_t     shift_word;
  int          bit_idx;
  int          cur_q;
  logic        active;

  initial
  begin
    $readmemh("sim/cad_cases.txt", exp_mem);
    result_cnt    = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    bit_idx       = 0;
    cur_q         = 0;
    active        = 1'b0;
    shift_word    = '0;
  end

  // ------------------------------------------------------------
  // Serial capture, LSB first
  // ------------------------------------------------------------
  always @(posedge clk)
  begin
    result_t full;
    full = {out_value, shift_word[`RESULT_W-1:1]};

    if (out_valid && (in_valid || in_valid2))
    begin
      $display("out_valid is high during load or index input");
      other_errs++;
    end
    if (!out_valid && out_value)
    begin
      $display("out_value is high while out_valid is low");
      other_errs++;
    end

    if (arm)
    begin
      cur_q      <= query_sel;
      result_cnt <= 0;
      bit_idx    <= 0;
      active     <= 1'b1;
    end
    else if (out_valid)
    begin
      if (!active)
      begin
        $display("out_valid is high with no query pending (rst_n=%0b)", rst_n);
        other_errs++;
      end
      else
      begin
        shift_word <= full;
        if (bit_idx == `RESULT_W - 1)
        begin
          if (full !== exp_mem[EXP_BASE + cur_q * RESULTS + result_cnt])
          begin
            $display("mismatch out_value: query %0d result %0d expected 0x%05h actual 0x%05h",
                     cur_q, result_cnt, exp_mem[EXP_BASE + cur_q * RESULTS + result_cnt],
                     full);
            mismatch_errs++;
          end
          bit_idx    <= 0;
          result_cnt <= result_cnt + 1;
          // Last result of this query
          if (result_cnt == RESULTS - 1)
            active <= 1'b0;
        end
        else
          bit_idx <= bit_idx + 1;
      end
    end
    else if (bit_idx != 0)
    begin
      $display("result cut short after %0d of %0d bits", bit_idx, `RESULT_W);
      other_errs++;
      bit_idx <= 0;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_cad.sv
`timescale 1ns/10ps
`include "cad_params.svh"
`default_nettype none

module tb_cad;

  localparam int QUERIES    = `QUERY_COUNT + 1;
  localparam int LOAD_BYTES = `IMG_DEPTH + `KER_DEPTH;
  localparam int QRY_BASE   = LOAD_BYTES;
  localparam int RESULTS    = `OUT_SIZE * `OUT_SIZE;
  localparam int CASE_WORDS = LOAD_BYTES + 2 * QUERIES + QUERIES * RESULTS;
  localparam int WAIT_LIMIT = 4000;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_valid2;
  logic [7:0] matrix;
  logic [3:0] matrix_idx;
  logic       out_valid;
  logic       out_value;
  logic       arm;
  int         query_sel;
  int         result_cnt;
  int         mismatch_errs;
  int         other_errs;
  int         timeout_errs;

  logic [19:0] cases_mem [CASE_WORDS];

  cad_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix     (matrix),
    .matrix_idx (matrix_idx),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

  cad_checker #(.num_queries(QUERIES)) u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_valid2     (in_valid2),
    .out_valid     (out_valid),
    .out_value     (out_value),
    .arm           (arm),
    .query_sel     (query_sel),
    .result_cnt    (result_cnt),
    .mismatch_errs (mismatch_errs),
    .other_errs    (other_errs)
  );

  always #20 clk = ~clk;

  // Source word for a reload with image and kernel order reversed
  function automatic int reversed_src(input int i);
    int n;
    int off;
    if (i < `IMG_DEPTH)
    begin
      n   = i / `IMG_PIXELS;
      off = i % `IMG_PIXELS;
      reversed_src = (`IMG_COUNT - 1 - n) * `IMG_PIXELS + off;
    end
    else
    begin
      n   = (i - `IMG_DEPTH) / `KER_TAPS;
      off = (i - `IMG_DEPTH) % `KER_TAPS;
      reversed_src = `IMG_DEPTH + (`KERNEL_COUNT - 1 - n) * `KER_TAPS + off;
    end
  endfunction

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  task automatic load_memories(input bit reversed);
    int src;
    for (int i = 0; i < LOAD_BYTES; i++)
    begin
      src = reversed ? reversed_src(i) : i;
      @(posedge clk);
      in_valid <= 1'b1;
      matrix   <= cases_mem[src][7:0];
    end
    @(posedge clk);
    in_valid <= 1'b0;
    matrix   <= '0;
  endtask

  task automatic run_query(input int q);
    int waited;
    @(posedge clk);
    in_valid2  <= 1'b1;
    matrix_idx <= cases_mem[QRY_BASE + 2 * q][3:0];
    arm        <= 1'b1;
    query_sel  <= q;
    @(posedge clk);
    matrix_idx <= cases_mem[QRY_BASE + 2 * q + 1][3:0];
    arm        <= 1'b0;
    @(posedge clk);
    in_valid2  <= 1'b0;
    matrix_idx <= '0;
    // Checker counts whole results as they arrive
    waited = 0;
    while (result_cnt < RESULTS && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (result_cnt < RESULTS)
    begin
      $display("timeout: query %0d returned %0d of %0d results", q, result_cnt, RESULTS);
      timeout_errs++;
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_valid2    = 1'b0;
    matrix       = '0;
    matrix_idx   = '0;
    arm          = 1'b0;
    query_sel    = 0;
    timeout_errs = 0;
    $readmemh("sim/cad_cases.txt", cases_mem);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    load_memories(1'b0);
    for (int q = 0; q < `QUERY_COUNT; q++)
      run_query(q);

    // Core should be idle again and take a fresh load
    load_memories(1'b1);
    run_query(`QUERY_COUNT);
    @(posedge clk);

    $display("errors: mismatch %0d, other %0d, timeout %0d",
             mismatch_errs, other_errs, timeout_errs);
    if (mismatch_errs + other_errs + timeout_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cad_cases.txt
// Load bytes: 8 image rows of 8 bytes per image, then 5 kernel rows of 5 bytes per kernel
// Then image/kernel index pairs per query, then 16 expected 20-bit results per query
// Image 0
E0 E1 E2 E3 E4 E5 E6 E7
E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7
F8 F9 FA FB FC FD FE FF
00 01 02 03 04 05 06 07
08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17
18 19 1A 1B 1C 1D 1E 1F
// Image 1
07 0A 0D 10 13 16 19 1C
02 05 08 0B 0E 11 14 17
FD 00 03 06 09 0C 0F 12
F8 FB FE 01 04 07 0A 0D
F3 F6 F9 FC FF 02 05 08
EE F1 F4 F7 FA FD 00 03
E9 EC EF F2 F5 F8 FB FE
E4 E7 EA ED F0 F3 F6 F9
// Kernel 0
01 00 00 00 00
00 00 00 00 00
00 00 03 00 00
00 00 00 00 00
00 00 00 00 FE
// Kernel 1
01 01 01 01 01
01 01 01 01 01
01 01 01 01 01
01 01 01 01 01
01 01 01 01 01
// Queries, the last one after the reversed reload
0 0
1 0
0 1
0 0
// Expected results in raster order
FFFAE FFFB0 FFFB2 FFFB4 FFFBE FFFC0 FFFC2 FFFC4 FFFCE FFFD0 FFFD2 FFFD4 FFFDE FFFE0 FFFE2 FFFE4
00012 00018 0001E 00024 00008 0000E 00014 0001A FFFFE 00004 0000A 00010 FFFF4 FFFFA 00000 00006
FFEA2 FFEBB FFED4 FFEED FFF6A FFF83 FFF9C FFFB5 00032 0004B 00064 0007D 000FA 00113 0012C 00145
0004B 00096 000E1 0012C FFFCE 00019 00064 000AF FFF51 FFF9C FFFE7 00032 FFED4 FFF1F FFF6A FFFB5

//--- cad_top.f
+incdir+hdl
hdl/cad_pkg.sv
hdl/sram_bank.sv
hdl/cad_ctrl.sv
hdl/conv_engine.sv
hdl/result_serializer.sv
hdl/cad_top.sv
sim/cad_properties.sv
sim/cad_checker.sv
sim/tb_cad.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cad_top testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f cad_top.f --top-module tb_cad -o sim_cad

./obj_dir/sim_cad | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
